/* src.f */
hw/cpu_bus_pkg.sv
hw/main_decoder.sv
hw/sub_decoder.sv
hw/irq_latches.sv
hw/cpu_rom.sv
hw/shared_ram_arbiter.sv
hw/shared_ram.sv
hw/cpu_bus_top.sv
testbench/cpu_bus_props.sv
testbench/tb_cpu_bus_top.sv

/* Bender.yml */
package:
  name: cpu_bus

sources:
  - files:
      - hw/cpu_bus_pkg.sv
      - hw/main_decoder.sv
      - hw/sub_decoder.sv
      - hw/irq_latches.sv
      - hw/cpu_rom.sv
      - hw/shared_ram_arbiter.sv
      - hw/shared_ram.sv
      - hw/cpu_bus_top.sv
  - target: test
    files:
      - testbench/cpu_bus_props.sv
      - testbench/tb_cpu_bus_top.sv

/* testbench/tb_cpu_bus_top.sv */
`timescale 1ns/1ps

module tb_cpu_bus_top import cpu_bus_pkg::*; ();

	// rom load dominates, the rest is a few hundred accesses
	localparam int LOAD_CYCLES  = 2 * 65536;
	localparam int OTHER_CYCLES = 1500;
	localparam int CYCLE_LIMIT  = 2 * (LOAD_CYCLES + OTHER_CYCLES);

	logic      clk = 1'b0;
	logic      RSTn;
	cpu_addr_t main_addr;
	logic      main_rw;
	logic      main_strobe;
	cpu_data_t main_wdata;
	cpu_data_t main_rdata;
	logic      main_wait;
	cpu_addr_t sub_addr;
	logic      sub_rw;
	logic      sub_strobe;
	cpu_data_t sub_wdata;
	cpu_data_t sub_rdata;
	logic      sub_wait;
	logic      bsl;
	logic      vblk;
	logic      ims;
	cpu_data_t db_in;
	cpu_data_t db_out;
	logic      map_sel_n;
	logic      back1_sel_n;
	logic      back2_sel_n;
	logic      obj_sel_n;
	logic      io_n;
	logic      pl_sel_n;
	logic      main_nmi_n;
	logic      main_firq_n;
	logic      main_irq_n;
	logic      sub_irq_n;
	logic      rom_load_wr;
	logic      rom_load_sel;
	cpu_addr_t rom_load_addr;
	cpu_data_t rom_load_data;

	// reference model state
	cpu_data_t  rom_img [2**17];
	cpu_data_t  ram_ref [2**SHARED_ADDR_W];
	logic       sub_turn;
	logic       bank_ref;
	logic [3:0] irq_pend;
	logic [3:0] set_d1;
	logic [3:0] set_d2;
	logic [3:0] clr_d1;
	logic [3:0] clr_d2;
	logic       vblk_prev;
	logic       ims_prev;
	logic       main_pend;
	logic       sub_pend;
	cpu_data_t  main_exp;
	cpu_data_t  sub_exp;
	logic [5:0] sel_exp;
	cpu_data_t  db_exp;

	cpu_addr_t   ram_addrs [$];
	logic        ram_ports [$];
	logic [31:0] lfsr = 32'h28c2c38d;
	int          checks = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          cycles = 0;

	cpu_bus_top u_dut (.*);

	always #10 clk = ~clk;

	// ******************************************************************
	// random bits, reference functions, check
	// ******************************************************************

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// image index is {select, load address}
	function automatic cpu_data_t rom_image_byte(input logic sel, input cpu_addr_t a,
		input logic bank);
		if (a >= FIXED_BASE)
			return rom_img[{sel, 1'b0, a[14:0]}];
		return rom_img[{sel, 1'b1, bank, a[13:0]}];
	endfunction

	function automatic cpu_data_t expected_main_read(input cpu_addr_t a, input logic bank,
		input cpu_data_t db);
		if (a <= SHARED_TOP)
			return ram_ref[a[SHARED_ADDR_W-1:0]];
		// video/io block is the external bus
		if (a < BANK_BASE)
			return db;
		return rom_image_byte(ROM_MAIN, a, bank);
	endfunction

	function automatic cpu_data_t expected_sub_read(input cpu_addr_t a);
		if (a <= SHARED_TOP)
			return ram_ref[a[SHARED_ADDR_W-1:0]];
		// nothing answers sub reads here
		if (a < BANK_BASE)
			return BUS_IDLE;
		return rom_image_byte(ROM_SUB, a, bank_ref);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ******************************************************************
	// comparison against the model, once per cycle at the falling edge
	// ******************************************************************

	always @(negedge clk) begin : compare
		logic       req_m;
		logic       req_s;
		logic       gnt_m;
		logic       gnt_s;
		logic       acc_m;
		logic       acc_s;
		logic       io_acc;
		logic [3:0] irq_exp;
		logic [3:0] set_now;
		logic [3:0] clr_now;
		if (!RSTn) begin
			// first conflict goes to sub
			sub_turn  = 1'b1;
			bank_ref  = 1'b0;
			irq_pend  = '0;
			set_d1    = '0;
			set_d2    = '0;
			clr_d1    = '0;
			clr_d2    = '0;
			vblk_prev = vblk;
			ims_prev  = ims;
			main_pend = 1'b0;
			sub_pend  = 1'b0;
			sel_exp   = '1;
			db_exp    = BUS_IDLE;
		end else begin
			// outputs registered at the last edge
			if (main_pend)
				check("main_rdata", main_rdata, main_exp);
			if (sub_pend)
				check("sub_rdata", sub_rdata, sub_exp);
			check("sel_n {map,back1,back2,obj,io,pl}",
				{map_sel_n, back1_sel_n, back2_sel_n, obj_sel_n, io_n, pl_sel_n}, sel_exp);
			check("db_out", db_out, db_exp);
			// events from two cycles back reach the outputs now
			irq_pend = (irq_pend | set_d2) & ~clr_d2;
			irq_exp  = ~irq_pend;
			check("irq_n {sub,main,firq,nmi}",
				{sub_irq_n, main_irq_n, main_firq_n, main_nmi_n}, irq_exp);
			// arbiter, loser of the last conflict goes first
			req_m = main_strobe && (main_addr <= SHARED_TOP);
			req_s = sub_strobe && (sub_addr <= SHARED_TOP);
			gnt_m = req_m && !(req_s && sub_turn);
			gnt_s = req_s && !(req_m && !sub_turn);
			check("main_wait", main_wait, req_m && !gnt_m);
			check("sub_wait", sub_wait, req_s && !gnt_s);
			if (req_m && req_s)
				sub_turn = !sub_turn;
			acc_m = main_strobe && (gnt_m || !req_m);
			acc_s = sub_strobe && (gnt_s || !req_s);
			// read data due next cycle
			main_pend = acc_m && main_rw;
			sub_pend  = acc_s && sub_rw;
			main_exp  = expected_main_read(main_addr, bsl, db_in);
			sub_exp   = expected_sub_read(sub_addr);
			// select strobes from the video/io map
			io_acc  = acc_m && (main_addr >= 16'h2000) && (main_addr <= 16'h3FFF);
			sel_exp = ~{io_acc && (main_addr < 16'h2800),
				io_acc && (main_addr >= 16'h2800) && (main_addr < 16'h3000),
				io_acc && (main_addr >= 16'h3000) && (main_addr < 16'h3800),
				io_acc && (main_addr >= 16'h3800) && (main_addr < 16'h3A00),
				io_acc && (main_addr >= 16'h3A00) && (main_addr < 16'h3C00),
				io_acc && (main_addr >= 16'h3C00)};
			db_exp = (io_acc && !main_rw) ? main_wdata : BUS_IDLE;
			// bit order nmi, firq, main irq, sub irq
			set_now = {acc_m && !main_rw && (main_addr == IO_SUB_IRQ_SET),
				acc_s && !sub_rw && (sub_addr >= 16'h2000) && (sub_addr < 16'h2800),
				ims && !ims_prev, vblk && !vblk_prev};
			clr_now = {acc_s && !sub_rw && (sub_addr >= 16'h2800) && (sub_addr < 16'h3000),
				acc_m && !main_rw && (main_addr == IO_IRQ_CLR),
				acc_m && !main_rw && (main_addr == IO_FIRQ_CLR),
				acc_m && !main_rw && (main_addr == IO_NMI_CLR)};
			set_d2    = set_d1;
			clr_d2    = clr_d1;
			set_d1    = set_now;
			clr_d1    = clr_now;
			vblk_prev = vblk;
			ims_prev  = ims;
			// writes land at the end of this cycle
			if (acc_m && !main_rw && req_m)
				ram_ref[main_addr[SHARED_ADDR_W-1:0]] = main_wdata;
			if (acc_s && !sub_rw && req_s)
				ram_ref[sub_addr[SHARED_ADDR_W-1:0]] = sub_wdata;
			if (acc_s && !sub_rw && (sub_addr >= 16'h3000) && (sub_addr < 16'h3800))
				bank_ref = sub_wdata[0];
		end
	end

	// ******************************************************************
	// bus access tasks
	// ******************************************************************

	task automatic main_access(input cpu_addr_t a, input logic rw, input cpu_data_t d,
		input logic b);
		@(posedge clk);
		main_addr   <= a;
		main_rw     <= rw;
		main_wdata  <= d;
		main_strobe <= 1'b1;
		bsl         <= b;
		db_in       <= cpu_data_t'(rand_bits(8));
		// levels stay put while refused
		@(negedge clk);
		while (main_wait)
			@(negedge clk);
		@(posedge clk);
		main_strobe <= 1'b0;
	endtask

	task automatic sub_access(input cpu_addr_t a, input logic rw, input cpu_data_t d);
		@(posedge clk);
		sub_addr   <= a;
		sub_rw     <= rw;
		sub_wdata  <= d;
		sub_strobe <= 1'b1;
		@(negedge clk);
		while (sub_wait)
			@(negedge clk);
		@(posedge clk);
		sub_strobe <= 1'b0;
	endtask

	// all four halves, main image first
	task automatic load_roms;
		cpu_data_t d;
		int i;
		for (i = 0; i < LOAD_CYCLES; i++) begin
			d = cpu_data_t'(rand_bits(8));
			@(posedge clk);
			rom_load_wr   <= 1'b1;
			rom_load_sel  <= i[16];
			rom_load_addr <= i[15:0];
			rom_load_data <= d;
			rom_img[i[16:0]] = d;
		end
		@(posedge clk);
		rom_load_wr <= 1'b0;
	endtask

	task automatic finish_test(input string name);
		// last access still in the compare pipeline
		repeat (3) @(negedge clk);
		$display("test %s finished, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// ******************************************************************
	// tests
	// ******************************************************************

	task automatic rom_load_and_fetch;
		int n;
		load_roms();
		for (n = 0; n < 24; n++) begin
			main_access(cpu_addr_t'(rand_bits(16)) | BANK_BASE, 1'b1, 8'h00,
				rand_bits(1) != 0);
			sub_access(cpu_addr_t'(rand_bits(16)) | BANK_BASE, 1'b1, 8'h00);
			// new sub page now and then
			if (n % 6 == 5)
				sub_access(SUB_BANK_REG, 1'b0, cpu_data_t'(rand_bits(8)));
		end
		finish_test("rom load and fetch");
	endtask

	task automatic shared_ram_traffic;
		cpu_addr_t a;
		cpu_data_t d;
		int n;
		for (n = 0; n < 32; n++) begin
			a = cpu_addr_t'(rand_bits(SHARED_ADDR_W));
			d = cpu_data_t'(rand_bits(8));
			if (n[0])
				sub_access(a, 1'b0, d);
			else
				main_access(a, 1'b0, d, bsl);
			ram_addrs.push_back(a);
			ram_ports.push_back(n[0]);
		end
		// read back through the other port
		for (n = 0; n < 32; n++) begin
			if (ram_ports[n])
				main_access(ram_addrs[n], 1'b1, 8'h00, bsl);
			else
				sub_access(ram_addrs[n], 1'b1, 8'h00);
		end
		finish_test("shared ram");
	endtask

	task automatic arbitration_conflicts;
		cpu_addr_t ma;
		cpu_addr_t sa;
		int n;
		for (n = 0; n < 8; n++) begin
			// one side reads a known byte, the other writes
			ma = n[0] ? ram_addrs[rand_bits(5)] : cpu_addr_t'(rand_bits(SHARED_ADDR_W));
			sa = n[0] ? cpu_addr_t'(rand_bits(SHARED_ADDR_W)) : ram_addrs[rand_bits(5)];
			fork
				main_access(ma, n[0], cpu_data_t'(rand_bits(8)), bsl);
				sub_access(sa, !n[0], cpu_data_t'(rand_bits(8)));
			join
		end
		finish_test("arbitration");
	endtask

	task automatic select_and_ext_bus;
		cpu_addr_t base [6] = '{16'h2000, 16'h2800, 16'h3000, 16'h3800, 16'h3A00, 16'h3C00};
		int n;
		for (n = 0; n < 6; n++) begin
			main_access(base[n] | cpu_addr_t'(rand_bits(9)), 1'b1, 8'h00, bsl);
			main_access(base[n] | cpu_addr_t'(rand_bits(9)), 1'b0,
				cpu_data_t'(rand_bits(8)), bsl);
		end
		// unmapped for sub
		for (n = 0; n < 4; n++)
			sub_access(16'h2000 | cpu_addr_t'(rand_bits(SHARED_ADDR_W)), 1'b1, 8'h00);
		finish_test("select strobes and external bus");
	endtask

	task automatic interrupt_handshakes;
		// nmi from vblank
		@(posedge clk);
		vblk <= 1'b1;
		repeat (3) @(posedge clk);
		vblk <= 1'b0;
		main_access(IO_NMI_CLR, 1'b0, cpu_data_t'(rand_bits(8)), bsl);
		// firq from the sound handshake
		@(posedge clk);
		ims <= 1'b1;
		repeat (3) @(posedge clk);
		ims <= 1'b0;
		main_access(IO_FIRQ_CLR, 1'b0, cpu_data_t'(rand_bits(8)), bsl);
		// sub raises main irq, main acks
		sub_access(SUB_MAIN_IRQ, 1'b0, cpu_data_t'(rand_bits(8)));
		main_access(IO_IRQ_CLR, 1'b0, cpu_data_t'(rand_bits(8)), bsl);
		// and the other way round
		main_access(IO_SUB_IRQ_SET, 1'b0, cpu_data_t'(rand_bits(8)), bsl);
		sub_access(SUB_IRQ_CLR, 1'b0, cpu_data_t'(rand_bits(8)));
		finish_test("interrupts");
	endtask

	// ******************************************************************
	// run control
	// ******************************************************************

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout, tests did not end within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		RSTn          = 1'b0;
		main_addr     = '0;
		main_rw       = 1'b1;
		main_strobe   = 1'b0;
		main_wdata    = '0;
		sub_addr      = '0;
		sub_rw        = 1'b1;
		sub_strobe    = 1'b0;
		sub_wdata     = '0;
		bsl           = 1'b0;
		vblk          = 1'b0;
		ims           = 1'b0;
		db_in         = '0;
		rom_load_wr   = 1'b0;
		rom_load_sel  = ROM_MAIN;
		rom_load_addr = '0;
		rom_load_data = '0;
		repeat (4) @(posedge clk);
		RSTn <= 1'b1;
		rom_load_and_fetch();
		shared_ram_traffic();
		arbitration_conflicts();
		select_and_ext_bus();
		interrupt_handshakes();
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			u_dut.u_arbiter.u_props.fail_count);
		if (errors == 0 && u_dut.u_arbiter.u_props.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* testbench/cpu_bus_props.sv */
`timescale 1ns/1ps

module cpu_bus_props import cpu_bus_pkg::*; (
	input logic      clk,
	input logic      RSTn,
	input logic      main_strobe,
	input logic      sub_strobe,
	input cpu_addr_t main_addr,
	input cpu_addr_t sub_addr,
	input logic      main_rw,
	input logic      sub_rw,
	input cpu_data_t main_wdata,
	input cpu_data_t sub_wdata,
	input logic      grant_main,
	input logic      grant_sub,
	input logic      main_wait,
	input logic      sub_wait
);

	// number of failed assertions
	int fail_count = 0;

	// ******************************************************************
	// grant rules
	// ******************************************************************

	// one ram port, one owner
	a_one_grant: assert property (@(posedge clk) disable iff (!RSTn)
		!(grant_main && grant_sub))
	else begin
		$error("arbiter granted both ports");
		fail_count++;
	end

	// a refused port only waits behind the other one
	// and wins the retry, round robin never refuses twice
	a_main_wait: assert property (@(posedge clk) disable iff (!RSTn)
		main_wait |-> grant_sub ##1 !main_wait)
	else begin
		$error("main wait without a sub grant, or refused twice");
		fail_count++;
	end

	a_sub_wait: assert property (@(posedge clk) disable iff (!RSTn)
		sub_wait |-> grant_main ##1 !sub_wait)
	else begin
		$error("sub wait without a main grant, or refused twice");
		fail_count++;
	end

	// ******************************************************************
	// refused request is held
	// ******************************************************************

	a_main_hold: assert property (@(posedge clk) disable iff (!RSTn)
		main_wait |=> main_strobe && $stable(main_addr) && $stable(main_rw)
			&& $stable(main_wdata))
	else begin
		$error("main request dropped or changed while waiting");
		fail_count++;
	end

	a_sub_hold: assert property (@(posedge clk) disable iff (!RSTn)
		sub_wait |=> sub_strobe && $stable(sub_addr) && $stable(sub_rw)
			&& $stable(sub_wdata))
	else begin
		$error("sub request dropped or changed while waiting");
		fail_count++;
	end

endmodule

bind shared_ram_arbiter cpu_bus_props u_props (
	.clk(clk), .RSTn(RSTn),
	.main_strobe(main_strobe), .sub_strobe(sub_strobe),
	.main_addr(main_addr), .sub_addr(sub_addr),
	.main_rw(main_rw), .sub_rw(sub_rw),
	.main_wdata(main_wdata), .sub_wdata(sub_wdata),
	.grant_main(grant_main), .grant_sub(grant_sub),
	.main_wait(main_wait), .sub_wait(sub_wait)
);

/* hw/cpu_bus_top.sv */
`timescale 1ns/1ps

module cpu_bus_top import cpu_bus_pkg::*; (
	input  logic      clk,
	input  logic      RSTn,
	// main cpu port
	input  cpu_addr_t main_addr,
	input  logic      main_rw,
	input  logic      main_strobe,
	input  cpu_data_t main_wdata,
	output cpu_data_t main_rdata,
	output logic      main_wait,
	// sub cpu port
	input  cpu_addr_t sub_addr,
	input  logic      sub_rw,
	input  logic      sub_strobe,
	input  cpu_data_t sub_wdata,
	output cpu_data_t sub_rdata,
	output logic      sub_wait,
	// board side
	input  logic      bsl,
	input  logic      vblk,
	input  logic      ims,
	input  cpu_data_t db_in,
	output cpu_data_t db_out,
	output logic      map_sel_n,
	output logic      back1_sel_n,
	output logic      back2_sel_n,
	output logic      obj_sel_n,
	output logic      io_n,
	output logic      pl_sel_n,
	output logic      main_nmi_n,
	output logic      main_firq_n,
	output logic      main_irq_n,
	output logic      sub_irq_n,
	// rom load
	input  logic      rom_load_wr,
	input  logic      rom_load_sel,
	input  cpu_addr_t rom_load_addr,
	input  cpu_data_t rom_load_data
);

	logic                     grant_main;
	logic                     grant_sub;
	logic [SHARED_ADDR_W-1:0] ram_addr;
	logic                     ram_we;
	cpu_data_t                ram_wdata;
	cpu_data_t                ram_rdata;

	logic      main_load_wr;
	logic      sub_load_wr;
	cpu_data_t main_rom_rdata;
	cpu_data_t sub_rom_rdata;
	logic      main_rom_hit;
	logic      sub_rom_hit;

	logic ext_rd;
	logic ext_wr;
	logic nmi_clr;
	logic firq_clr;
	logic irq_clr;
	logic sub_irq_set;
	logic main_irq_set;
	logic sub_irq_clr;
	logic sub_bank;

	// read taken last cycle, and whether ram served it
	logic      main_rd_q;
	logic      main_ram_q;
	logic      sub_rd_q;
	logic      sub_ram_q;
	cpu_data_t db_in_q;
	cpu_data_t wdata_q;

	// ******************************************************************
	// shared ram
	// ******************************************************************

	shared_ram_arbiter u_arbiter (
		.clk(clk), .RSTn(RSTn),
		.main_strobe(main_strobe), .sub_strobe(sub_strobe),
		.main_addr(main_addr), .sub_addr(sub_addr),
		.main_rw(main_rw), .sub_rw(sub_rw),
		.main_wdata(main_wdata), .sub_wdata(sub_wdata),
		.grant_main(grant_main), .grant_sub(grant_sub),
		.main_wait(main_wait), .sub_wait(sub_wait),
		.ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata)
	);

	shared_ram u_ram (
		.clk(clk), .addr(ram_addr), .we(ram_we),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

	// ******************************************************************
	// roms, load port split by select
	// ******************************************************************

	assign main_load_wr = rom_load_wr && (rom_load_sel == ROM_MAIN);
	assign sub_load_wr  = rom_load_wr && (rom_load_sel == ROM_SUB);

	// main page bit comes straight from bsl
	cpu_rom u_main_rom (
		.clk(clk), .cpu_addr(main_addr), .bank(bsl),
		.load_wr(main_load_wr), .load_addr(rom_load_addr), .load_data(rom_load_data),
		.rdata(main_rom_rdata), .hit(main_rom_hit)
	);

	cpu_rom u_sub_rom (
		.clk(clk), .cpu_addr(sub_addr), .bank(sub_bank),
		.load_wr(sub_load_wr), .load_addr(rom_load_addr), .load_data(rom_load_data),
		.rdata(sub_rom_rdata), .hit(sub_rom_hit)
	);

	// ******************************************************************
	// decode and interrupts
	// ******************************************************************

	main_decoder u_main_dec (
		.clk(clk), .RSTn(RSTn),
		.main_addr(main_addr), .main_rw(main_rw),
		.main_strobe(main_strobe), .main_wait(main_wait),
		.map_sel_n(map_sel_n), .back1_sel_n(back1_sel_n), .back2_sel_n(back2_sel_n),
		.obj_sel_n(obj_sel_n), .io_n(io_n), .pl_sel_n(pl_sel_n),
		.nmi_clr(nmi_clr), .firq_clr(firq_clr), .irq_clr(irq_clr),
		.sub_irq_set(sub_irq_set), .ext_rd(ext_rd), .ext_wr(ext_wr)
	);

	sub_decoder u_sub_dec (
		.clk(clk), .RSTn(RSTn),
		.sub_addr(sub_addr), .sub_rw(sub_rw), .sub_strobe(sub_strobe),
		.sub_wdata(sub_wdata),
		.main_irq_set(main_irq_set), .sub_irq_clr(sub_irq_clr), .sub_bank(sub_bank)
	);

	irq_latches u_irq (
		.clk(clk), .RSTn(RSTn), .vblk(vblk), .ims(ims),
		.nmi_clr(nmi_clr), .firq_clr(firq_clr), .irq_clr(irq_clr),
		.main_irq_set(main_irq_set), .sub_irq_set(sub_irq_set),
		.sub_irq_clr(sub_irq_clr),
		.main_nmi_n(main_nmi_n), .main_firq_n(main_firq_n),
		.main_irq_n(main_irq_n), .sub_irq_n(sub_irq_n)
	);

	// ******************************************************************
	// read source tracking and data muxes
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			main_rd_q  <= 1'b0;
			main_ram_q <= 1'b0;
			sub_rd_q   <= 1'b0;
			sub_ram_q  <= 1'b0;
		end else begin
			main_rd_q  <= main_strobe && !main_wait && main_rw;
			// a grant is already an accept
			main_ram_q <= grant_main && main_rw;
			sub_rd_q   <= sub_strobe && !sub_wait && sub_rw;
			sub_ram_q  <= grant_sub && sub_rw;
		end
	end

	// bus payload, sampled every cycle
	always_ff @(posedge clk) begin
		db_in_q <= db_in;
		wdata_q <= main_wdata;
	end

	always_comb begin
		if (main_rd_q && main_rom_hit)
			main_rdata = main_rom_rdata;
		else if (main_ram_q)
			main_rdata = ram_rdata;
		else if (ext_rd)
			main_rdata = db_in_q;
		else
			main_rdata = BUS_IDLE;
	end

	// sub has no external bus, 0x2000-0x3fff reads float
	always_comb begin
		if (sub_rd_q && sub_rom_hit)
			sub_rdata = sub_rom_rdata;
		else if (sub_ram_q)
			sub_rdata = ram_rdata;
		else
			sub_rdata = BUS_IDLE;
	end

	// main write byte only while an external write is on the bus
	assign db_out = ext_wr ? wdata_q : BUS_IDLE;

endmodule

/* hw/shared_ram.sv */
`timescale 1ns/1ps

module shared_ram import cpu_bus_pkg::*; (
	input  logic                     clk,
	input  logic [SHARED_ADDR_W-1:0] addr,
	input  logic                     we,
	input  cpu_data_t                wdata,
	output cpu_data_t                rdata
);

	// 8K work ram, like the 6264 on the board
	cpu_data_t mem [2**SHARED_ADDR_W];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		// read returns the old byte on a write cycle
		rdata <= mem[addr];
	end

endmodule

/* hw/shared_ram_arbiter.sv */
`timescale 1ns/1ps

module shared_ram_arbiter import cpu_bus_pkg::*; (
	input  logic                     clk,
	input  logic                     RSTn,
	input  logic                     main_strobe,
	input  logic                     sub_strobe,
	input  cpu_addr_t                main_addr,
	input  cpu_addr_t                sub_addr,
	input  logic                     main_rw,
	input  logic                     sub_rw,
	input  cpu_data_t                main_wdata,
	input  cpu_data_t                sub_wdata,
	output logic                     grant_main,
	output logic                     grant_sub,
	output logic                     main_wait,
	output logic                     sub_wait,
	output logic [SHARED_ADDR_W-1:0] ram_addr,
	output logic                     ram_we,
	output cpu_data_t                ram_wdata
);

	logic main_req;
	logic sub_req;
	logic conflict;
	// main wins the next conflict
	logic main_first;

	// only the shared window competes
	assign main_req = main_strobe && (main_addr <= SHARED_TOP);
	assign sub_req  = sub_strobe && (sub_addr <= SHARED_TOP);
	assign conflict = main_req && sub_req;

	// ******************************************************************
	// round robin grant
	// ******************************************************************

	assign grant_main = main_req && (!sub_req || main_first);
	assign grant_sub  = sub_req && (!main_req || !main_first);

	// refused port retries with the same levels
	assign main_wait = main_req && !grant_main;
	assign sub_wait  = sub_req && !grant_sub;

	// loser of this conflict goes first next time
	always_ff @(posedge clk) begin
		if (!RSTn) begin
			main_first <= 1'b0;
		end else if (conflict) begin
			main_first <= !main_first;
		end
	end

	// ******************************************************************
	// ram port steering, the old 74157 muxes
	// ******************************************************************

	assign ram_addr = grant_sub ? sub_addr[SHARED_ADDR_W-1:0] :
		main_addr[SHARED_ADDR_W-1:0];

	assign ram_we = (grant_main && !main_rw) || (grant_sub && !sub_rw);

	// data from whoever holds the grant
	assign ram_wdata = grant_sub ? sub_wdata : main_wdata;

endmodule

/* hw/cpu_rom.sv */
`timescale 1ns/1ps

module cpu_rom import cpu_bus_pkg::*; (
	input  logic      clk,
	input  cpu_addr_t cpu_addr,
	input  logic      bank,
	input  logic      load_wr,
	input  cpu_addr_t load_addr,
	input  cpu_data_t load_data,
	output cpu_data_t rdata,
	output logic      hit
);

	// fixed half 0x8000-0xffff, banked half two 16K pages
	cpu_data_t fixed_mem [2**ROM_ADDR_W];
	cpu_data_t bank_mem  [2**ROM_ADDR_W];

	logic [ROM_ADDR_W-1:0] bank_addr;
	cpu_data_t             fixed_q;
	cpu_data_t             bank_q;
	logic                  fixed_sel_q;

	// page bit on top of a13..a0
	assign bank_addr = {bank, cpu_addr[ROM_ADDR_W-2:0]};

	// load port, a15 picks the half
	always_ff @(posedge clk) begin
		if (load_wr && !load_addr[15])
			fixed_mem[load_addr[ROM_ADDR_W-1:0]] <= load_data;
		if (load_wr && load_addr[15])
			bank_mem[load_addr[ROM_ADDR_W-1:0]] <= load_data;
	end

	// both halves read every cycle
	always_ff @(posedge clk) begin
		fixed_q     <= fixed_mem[cpu_addr[ROM_ADDR_W-1:0]];
		bank_q      <= bank_mem[bank_addr];
		fixed_sel_q <= cpu_addr >= FIXED_BASE;
		// anything from 0x4000 up is rom
		hit         <= cpu_addr >= BANK_BASE;
	end

	assign rdata = fixed_sel_q ? fixed_q : bank_q;

endmodule

/* hw/irq_latches.sv */
`timescale 1ns/1ps

module irq_latches (
	input  logic clk,
	input  logic RSTn,
	input  logic vblk,
	input  logic ims,
	input  logic nmi_clr,
	input  logic firq_clr,
	input  logic irq_clr,
	input  logic main_irq_set,
	input  logic sub_irq_set,
	input  logic sub_irq_clr,
	output logic main_nmi_n,
	output logic main_firq_n,
	output logic main_irq_n,
	output logic sub_irq_n
);

	// bit 0 vblk, bit 1 ims
	logic [1:0] ext_sync;
	logic [1:0] ext_prev;
	logic [1:0] ext_rise;

	// bit order: nmi, firq, main irq, sub irq
	logic [3:0] set_ev;
	logic [3:0] clr_ev;
	logic [3:0] pend;

	// rising edge of the synced levels
	assign ext_rise = ext_sync & ~ext_prev;

	assign set_ev = {sub_irq_set, main_irq_set, ext_rise[1], ext_rise[0]};
	assign clr_ev = {sub_irq_clr, irq_clr, firq_clr, nmi_clr};

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			ext_sync <= 2'b00;
			ext_prev <= 2'b00;
			pend     <= 4'b0000;
		end else begin
			ext_sync <= {ims, vblk};
			ext_prev <= ext_sync;
			// clear wins over a set in the same cycle
			pend <= (pend | set_ev) & ~clr_ev;
		end
	end

	// active low to the cpus
	assign main_nmi_n  = !pend[0];
	assign main_firq_n = !pend[1];
	assign main_irq_n  = !pend[2];
	assign sub_irq_n   = !pend[3];

endmodule

/* hw/sub_decoder.sv */
`timescale 1ns/1ps

module sub_decoder import cpu_bus_pkg::*; (
	input  logic      clk,
	input  logic      RSTn,
	input  cpu_addr_t sub_addr,
	input  logic      sub_rw,
	input  logic      sub_strobe,
	input  cpu_data_t sub_wdata,
	output logic      main_irq_set,
	output logic      sub_irq_clr,
	output logic      sub_bank
);

	logic sub_wr;
	logic hit_irq;
	logic hit_ack;
	logic hit_bank;

	// sub never waits outside shared ram, strobe alone is enough
	assign sub_wr = sub_strobe && !sub_rw;

	// 2K block compare, a15..a11
	assign hit_irq  = sub_addr[15:11] == SUB_MAIN_IRQ[15:11];
	assign hit_ack  = sub_addr[15:11] == SUB_IRQ_CLR[15:11];
	assign hit_bank = sub_addr[15:11] == SUB_BANK_REG[15:11];

	// ******************************************************************
	// interrupt handshake pulses
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			main_irq_set <= 1'b0;
			sub_irq_clr  <= 1'b0;
		end else begin
			// request to main
			main_irq_set <= sub_wr && hit_irq;
			// acknowledge of the irq from main
			sub_irq_clr  <= sub_wr && hit_ack;
		end
	end

	// ******************************************************************
	// rom bank register
	// ******************************************************************

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			sub_bank <= 1'b0;
		end else if (sub_wr && hit_bank) begin
			// only d0 is wired
			sub_bank <= sub_wdata[0];
		end
	end

endmodule

/* hw/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder import cpu_bus_pkg::*; (
	input  logic      clk,
	input  logic      RSTn,
	input  cpu_addr_t main_addr,
	input  logic      main_rw,
	input  logic      main_strobe,
	input  logic      main_wait,
	output logic      map_sel_n,
	output logic      back1_sel_n,
	output logic      back2_sel_n,
	output logic      obj_sel_n,
	output logic      io_n,
	output logic      pl_sel_n,
	output logic      nmi_clr,
	output logic      firq_clr,
	output logic      irq_clr,
	output logic      sub_irq_set,
	output logic      ext_rd,
	output logic      ext_wr
);

	logic acc;
	logic io_space;
	logic io_wr;

	// access taken this cycle
	assign acc = main_strobe && !main_wait;

	// video/io block 0x2000-0x3fff, goes out on the external bus
	assign io_space = acc && (main_addr[15:13] == 3'b001);
	assign io_wr    = io_space && !main_rw;

	always_ff @(posedge clk) begin
		if (!RSTn) begin
			map_sel_n   <= 1'b1;
			back1_sel_n <= 1'b1;
			back2_sel_n <= 1'b1;
			obj_sel_n   <= 1'b1;
			io_n        <= 1'b1;
			pl_sel_n    <= 1'b1;
			nmi_clr     <= 1'b0;
			firq_clr    <= 1'b0;
			irq_clr     <= 1'b0;
			sub_irq_set <= 1'b0;
			ext_rd      <= 1'b0;
			ext_wr      <= 1'b0;
		end else begin
			// lower three 2K blocks, like the 74138 outputs
			map_sel_n   <= !(io_space && (main_addr[12:11] == 2'b00));
			back1_sel_n <= !(io_space && (main_addr[12:11] == 2'b01));
			back2_sel_n <= !(io_space && (main_addr[12:11] == 2'b10));
			// last 2K split again on a10..a9
			obj_sel_n <= !(io_space && (main_addr[12:9] == 4'b1100));
			io_n      <= !(io_space && (main_addr[12:9] == 4'b1101));
			// palette takes both upper 512 byte pieces
			pl_sel_n  <= !(io_space && (main_addr[12:10] == 3'b111));
			// one cycle command pulses for the latches
			nmi_clr     <= io_wr && (main_addr == IO_NMI_CLR);
			firq_clr    <= io_wr && (main_addr == IO_FIRQ_CLR);
			irq_clr     <= io_wr && (main_addr == IO_IRQ_CLR);
			sub_irq_set <= io_wr && (main_addr == IO_SUB_IRQ_SET);
			// direction of the external access for the top bus regs
			ext_rd <= io_space && main_rw;
			ext_wr <= io_wr;
		end
	end

endmodule

/* hw/cpu_bus_pkg.sv */
package cpu_bus_pkg;

	// ******************************************************************
	// bus types
	// ******************************************************************

	// 6809 address and data
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// shared work ram is 8K
	localparam int SHARED_ADDR_W = 13;
	// one rom half is 32K
	localparam int ROM_ADDR_W = 15;

	// value read where the board bus would float
	localparam cpu_data_t BUS_IDLE = 8'hFF;

	// ******************************************************************
	// memory map, both processors
	// ******************************************************************

	// last byte of the shared ram window
	localparam cpu_addr_t SHARED_TOP = 16'h1FFF;
	// banked rom window 0x4000-0x7fff
	localparam cpu_addr_t BANK_BASE = 16'h4000;
	// fixed rom 0x8000-0xffff
	localparam cpu_addr_t FIXED_BASE = 16'h8000;

	// main io writes
	localparam cpu_addr_t IO_NMI_CLR     = 16'h3A09;
	localparam cpu_addr_t IO_FIRQ_CLR    = 16'h3A0A;
	localparam cpu_addr_t IO_IRQ_CLR     = 16'h3A0B;
	localparam cpu_addr_t IO_SUB_IRQ_SET = 16'h3A0C;

	// sub writes, each one decodes a 2K block
	localparam cpu_addr_t SUB_MAIN_IRQ = 16'h2000;
	localparam cpu_addr_t SUB_IRQ_CLR  = 16'h2800;
	localparam cpu_addr_t SUB_BANK_REG = 16'h3000;

	// rom load port target
	localparam logic ROM_MAIN = 1'b0;
	localparam logic ROM_SUB  = 1'b1;

endpackage
